/* test/pet_bus_stimulus.txt */
// op_addr_wdata_status_expread_controls, one test per line, hex
// op 0 read, 1 write, 2 first RAM write, 3 random RAM, f end; controls ready,reset,nmi,col80,mask
0_801_00_0_02_10  // CPU register after reset
0_802_00_0_00_10
0_800_00_5_05_10  // Status follows the inputs
0_800_00_2_02_10
1_800_ff_3_03_10  // Status write does not stick
0_800_00_6_06_10
1_801_05_0_02_28  // Ready and NMI, out of reset
0_801_00_0_05_28
1_801_01_0_05_20
1_802_07_0_00_27  // 80 columns, mask 3
0_802_00_0_07_27
1_802_04_0_07_22
1_802_fa_0_04_21  // Upper bits kept
0_802_00_0_fa_21
2_000_41_0_00_21  // Video RAM ends of the window
2_3ff_5a_0_00_21
0_000_00_0_41_21
1_000_c3_0_41_21
0_000_00_0_c3_21
0_3ff_00_0_5a_21
0_400_00_0_ff_21  // Hole above the RAM
0_803_00_0_ff_21  // Register offset 3
1_803_00_0_ff_21
1_400_ff_0_ff_21
0_000_00_0_c3_21  // RAM byte 0 not aliased by 0x400
0_fff_00_0_ff_21
0_804_00_0_ff_21
3_000_00_0_00_21
3_000_00_0_00_21
3_000_00_0_00_21
1_801_02_0_01_11  // Back into reset
f_000_00_0_00_00

/* flist.f */
+incdir+include
hdl/common_pkg.sv
hdl/wb_host_bridge.sv
hdl/wb_decoder.sv
hdl/register_file.sv
hdl/video_ram.sv
hdl/pet_bus_top.sv
test/tb_pet_bus.sv

/* run_sim.sh */
#!/bin/sh
# Compile the bus testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_pet_bus -f flist.f -o sim_pet_bus \
    || { echo "Verilator build failed"; exit 1; }
result=$(./obj_dir/sim_pet_bus 2>&1)
echo "$result"
echo "$result" | grep -qF '*** TEST PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* test/tb_pet_bus.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module tb_pet_bus import common_pkg::*; ();
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_TIMEOUT = 16;      // Cycles allowed per command
    localparam int CMD_LATENCY  = 3;       // cmd_valid_i edge to done_o edge
    localparam int MAX_TESTS    = 64;
    localparam int REC_WIDTH    = 44;      // op, addr, wdata, status, read, controls
    localparam int RAM_WORDS    = 2**`RAM_ADDR_WIDTH;
    localparam int RAND_SEED    = 54006;

    typedef enum logic [3:0] {
        OP_READ       = 4'h0,
        OP_WRITE      = 4'h1,      // Old value checked
        OP_WRITE_NEW  = 4'h2,      // First write to a RAM byte, old value unknown
        OP_RANDOM_RAM = 4'h3,      // Write, overwrite, read back at a random byte
        OP_END        = 4'hf
    } op_t;

    logic                      wb_clock_i;
    logic                      reset_i;
    logic                      cmd_valid_i;
    logic                      cmd_we_i;
    logic [`WB_ADDR_WIDTH-1:0] cmd_addr_i;
    logic [`DATA_WIDTH-1:0]    cmd_data_i;
    logic                      busy_o;
    logic                      done_o;
    logic [`DATA_WIDTH-1:0]    rd_data_o;
    logic                      video_graphic_i;
    logic                      config_crt_i;
    logic                      config_keyboard_i;
    logic                      cpu_ready_o;
    logic                      cpu_reset_o;
    logic                      cpu_nmi_o;
    logic                      video_col_80_mode_o;
    logic [1:0]                video_ram_mask_o;

    logic [REC_WIDTH-1:0]      tests [MAX_TESTS];
    logic [`DATA_WIDTH-1:0]    ram_model [RAM_WORDS];     // Expected video RAM contents
    bit                        ram_known [RAM_WORDS];     // Byte written at least once
    integer                    seed;
    int                        test_errors;               // Mismatches in the current test
    int                        error_count;
    int                        test_count;
    int                        failed_tests;

    pet_bus_top UUT (.*);

    initial begin
        wb_clock_i = 1'b0;
        forever #(CLK_PERIOD/2) wb_clock_i = ~wb_clock_i;
    end

    // Address map as seen from the host
    function automatic periph_sel_t decode_target(input logic [`WB_ADDR_WIDTH-1:0] addr);
        if (addr - `RAM_BASE < RAM_WORDS) return PERIPH_RAM;
        if (addr >= `REG_BASE && addr < `REG_BASE + `REG_COUNT) return PERIPH_REG;
        return PERIPH_NONE;
    endfunction

    task automatic model_write(input logic [`WB_ADDR_WIDTH-1:0] addr,
                               input logic [`DATA_WIDTH-1:0] data);
        if (decode_target(addr) == PERIPH_RAM) begin
            ram_model[addr[`RAM_ADDR_WIDTH-1:0]] = data;
            ram_known[addr[`RAM_ADDR_WIDTH-1:0]] = 1'b1;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic check_data(input logic [`DATA_WIDTH-1:0] actual,
                              input logic [`DATA_WIDTH-1:0] expected);
        if (actual !== expected) report_mismatch("rd_data_o", expected, actual);
    endtask

    // Expected byte: bit 5 ready, 4 reset, 3 nmi, 2 col 80, 1:0 RAM mask
    task automatic check_controls(input logic ready, input logic reset, input logic nmi,
                                  input logic col_80, input logic [1:0] ram_mask,
                                  input logic [7:0] expected);
        if (ready !== expected[5]) report_mismatch("cpu_ready_o", 8'(expected[5]), 8'(ready));
        if (reset !== expected[4]) report_mismatch("cpu_reset_o", 8'(expected[4]), 8'(reset));
        if (nmi !== expected[3]) report_mismatch("cpu_nmi_o", 8'(expected[3]), 8'(nmi));
        if (col_80 !== expected[2]) begin
            report_mismatch("video_col_80_mode_o", 8'(expected[2]), 8'(col_80));
        end
        if (ram_mask !== expected[1:0]) begin
            report_mismatch("video_ram_mask_o", 8'(expected[1:0]), 8'(ram_mask));
        end
    endtask

    // Single-bit host port levels, busy_o and done_o
    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) report_mismatch(name, 8'(expected), 8'(actual));
    endtask

    task automatic check_latency(input int actual);
        if (actual != CMD_LATENCY) begin
            report_mismatch("done_o latency", 8'(CMD_LATENCY), 8'(actual));
        end
    endtask

    // One host command, returns the read data seen with done_o
    task automatic run_command(input logic we, input logic [`WB_ADDR_WIDTH-1:0] addr,
                               input logic [`DATA_WIDTH-1:0] data,
                               output logic [`DATA_WIDTH-1:0] rd);
        int cycles;
        bit seen;
        @(posedge wb_clock_i);
        cmd_valid_i <= 1'b1;
        cmd_we_i    <= we;
        cmd_addr_i  <= addr;
        cmd_data_i  <= data;
        @(posedge wb_clock_i);                 // DUT takes the command here
        cmd_valid_i <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge wb_clock_i);             // Outputs settled mid cycle
            cycles++;
            check_level("busy_o", busy_o, 1'b1);    // Busy through the done cycle
            if (done_o) seen = 1'b1;
        end
        if (!seen) begin
            $display("Timeout: no done_o within %0d cycles of the command to address %h",
                     DONE_TIMEOUT, addr);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            rd = rd_data_o;
            check_latency(cycles);
            @(negedge wb_clock_i);
            check_level("done_o", done_o, 1'b0);    // Pulse lasts one cycle
            check_level("busy_o", busy_o, 1'b0);
        end
    endtask

    task automatic random_ram_test(output logic [`WB_ADDR_WIDTH-1:0] bus_addr);
        int                         rnd;
        logic [`RAM_ADDR_WIDTH-1:0] ram_addr;
        logic [`DATA_WIDTH-1:0]     first;
        logic [`DATA_WIDTH-1:0]     second;
        logic [`DATA_WIDTH-1:0]     rd;
        rnd      = $random(seed);
        ram_addr = rnd[`RAM_ADDR_WIDTH-1:0];
        rnd      = $random(seed);
        first    = rnd[`DATA_WIDTH-1:0];
        rnd      = $random(seed);
        second   = rnd[`DATA_WIDTH-1:0];
        bus_addr = `RAM_BASE + {{(`WB_ADDR_WIDTH-`RAM_ADDR_WIDTH){1'b0}}, ram_addr};
        run_command(1'b1, bus_addr, first, rd);
        if (ram_known[ram_addr]) check_data(rd, ram_model[ram_addr]);
        model_write(bus_addr, first);
        run_command(1'b1, bus_addr, second, rd);   // Returns the first byte
        check_data(rd, ram_model[ram_addr]);
        model_write(bus_addr, second);
        run_command(1'b0, bus_addr, '0, rd);
        check_data(rd, ram_model[ram_addr]);
    endtask

    task automatic run_test(input int num, input logic [REC_WIDTH-1:0] rec);
        op_t                       op;
        logic [`WB_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]    wdata;
        logic [`DATA_WIDTH-1:0]    rd;
        logic [2:0]                sts;
        string                     kind;
        op          = op_t'(rec[43:40]);
        addr        = rec[39:28];
        wdata       = rec[27:20];
        sts         = rec[18:16];
        test_errors = 0;
        @(posedge wb_clock_i);                 // Status settles a cycle before the command
        {config_keyboard_i, config_crt_i, video_graphic_i} <= sts;
        case (op)
            OP_READ: begin
                kind = "read";
                run_command(1'b0, addr, wdata, rd);
                check_data(rd, rec[15:8]);
            end
            OP_WRITE: begin
                kind = "write";
                run_command(1'b1, addr, wdata, rd);
                check_data(rd, rec[15:8]);
                model_write(addr, wdata);
            end
            OP_WRITE_NEW: begin
                kind = "first write";
                run_command(1'b1, addr, wdata, rd);
                model_write(addr, wdata);
            end
            OP_RANDOM_RAM: begin
                kind = "random RAM";
                random_ram_test(addr);
            end
            default: begin
                kind = "unknown";
                $display("Test %0d: unknown opcode %h in the stimulus file", num, rec[43:40]);
                test_errors++;
            end
        endcase
        check_controls(cpu_ready_o, cpu_reset_o, cpu_nmi_o, video_col_80_mode_o,
                       video_ram_mask_o, rec[7:0]);
        test_count++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("Test %0d: %s at %h, pass", num, kind, addr);
        end else begin
            failed_tests++;
            $display("Test %0d: %s at %h, fail with %0d mismatches", num, kind, addr, test_errors);
        end
    endtask

    initial begin
        int idx;
        reset_i           = 1'b1;
        cmd_valid_i       = 1'b0;
        cmd_we_i          = 1'b0;
        cmd_addr_i        = '0;
        cmd_data_i        = '0;
        video_graphic_i   = 1'b0;
        config_crt_i      = 1'b0;
        config_keyboard_i = 1'b0;
        seed              = RAND_SEED;
        test_errors       = 0;
        error_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        for (idx = 0; idx < MAX_TESTS; idx++) tests[idx] = {OP_END, 40'h0};
        for (idx = 0; idx < RAM_WORDS; idx++) ram_known[idx] = 1'b0;
        $readmemh("test/pet_bus_stimulus.txt", tests);
        repeat (RESET_CYCLES) @(posedge wb_clock_i);
        reset_i <= 1'b0;
        idx = 0;
        while (idx < MAX_TESTS && op_t'(tests[idx][43:40]) != OP_END) begin
            run_test(idx + 1, tests[idx]);
            idx++;
        end
        $display("Tests run %0d, tests failed %0d, mismatches %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

/* hdl/pet_bus_top.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module pet_bus_top (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,

    // Host command port
    input  logic                      cmd_valid_i,
    input  logic                      cmd_we_i,
    input  logic [`WB_ADDR_WIDTH-1:0] cmd_addr_i,
    input  logic [`DATA_WIDTH-1:0]    cmd_data_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic [`DATA_WIDTH-1:0]    rd_data_o,

    // Status inputs
    input  logic                      video_graphic_i,
    input  logic                      config_crt_i,
    input  logic                      config_keyboard_i,

    // CPU and video control
    output logic                      cpu_ready_o,
    output logic                      cpu_reset_o,
    output logic                      cpu_nmi_o,
    output logic                      video_col_80_mode_o,
    output logic [1:0]                video_ram_mask_o
);
    // Shared bus from the bridge
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`WB_ADDR_WIDTH-1:0] wb_addr;
    logic [`DATA_WIDTH-1:0]    wb_wdata;
    // Merged reply from the decoder
    logic [`DATA_WIDTH-1:0]    wb_rdata;
    logic                      wb_ack;
    logic                      wb_stall;

    logic                      ram_sel,   reg_sel;
    logic [`DATA_WIDTH-1:0]    ram_rdata, reg_rdata;
    logic                      ram_ack,   reg_ack;
    logic                      ram_stall, reg_stall;

    wb_host_bridge bridge (
        .wb_clock_i, .reset_i,
        .cmd_valid_i, .cmd_we_i, .cmd_addr_i, .cmd_data_i,
        .busy_o, .done_o, .rd_data_o,
        .wbm_cyc_o(wb_cyc), .wbm_stb_o(wb_stb), .wbm_we_o(wb_we),
        .wbm_addr_o(wb_addr), .wbm_data_o(wb_wdata),
        .wbm_data_i(wb_rdata), .wbm_ack_i(wb_ack), .wbm_stall_i(wb_stall)
    );

    wb_decoder decoder (
        .wb_clock_i, .reset_i,
        .wbm_cyc_i(wb_cyc), .wbm_stb_i(wb_stb), .wbm_addr_i(wb_addr),
        .wbm_data_o(wb_rdata), .wbm_ack_o(wb_ack), .wbm_stall_o(wb_stall),
        .ram_sel_o(ram_sel), .reg_sel_o(reg_sel),
        .ram_data_i(ram_rdata), .ram_ack_i(ram_ack), .ram_stall_i(ram_stall),
        .reg_data_i(reg_rdata), .reg_ack_i(reg_ack), .reg_stall_i(reg_stall)
    );

    register_file registers (
        .wb_clock_i, .reset_i,
        .wbp_addr_i(wb_addr), .wbp_data_i(wb_wdata), .wbp_data_o(reg_rdata),
        .wbp_we_i(wb_we), .wbp_cycle_i(wb_cyc), .wbp_strobe_i(wb_stb),
        .wbp_sel_i(reg_sel), .wbp_stall_o(reg_stall), .wbp_ack_o(reg_ack),
        .video_graphic_i, .config_crt_i, .config_keyboard_i,
        .cpu_ready_o, .cpu_reset_o, .cpu_nmi_o,
        .video_col_80_mode_o, .video_ram_mask_o
    );

    video_ram vram (
        .wb_clock_i, .reset_i,
        .wbp_addr_i(wb_addr), .wbp_data_i(wb_wdata), .wbp_data_o(ram_rdata),
        .wbp_we_i(wb_we), .wbp_cycle_i(wb_cyc), .wbp_strobe_i(wb_stb),
        .wbp_sel_i(ram_sel), .wbp_stall_o(ram_stall), .wbp_ack_o(ram_ack)
    );
endmodule

/* hdl/video_ram.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module video_ram (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,

    // Wishbone B4 peripheral port
    input  logic [`WB_ADDR_WIDTH-1:0] wbp_addr_i,
    input  logic [`DATA_WIDTH-1:0]    wbp_data_i,
    output logic [`DATA_WIDTH-1:0]    wbp_data_o,
    input  logic                      wbp_we_i,
    input  logic                      wbp_cycle_i,
    input  logic                      wbp_strobe_i,
    input  logic                      wbp_sel_i,
    output logic                      wbp_stall_o,
    output logic                      wbp_ack_o
);
    logic [`DATA_WIDTH-1:0]    mem [2**`RAM_ADDR_WIDTH];
    logic [`RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                       accept;

    assign ram_addr = wbp_addr_i[`RAM_ADDR_WIDTH-1:0];     // Window offset only
    assign accept   = wbp_cycle_i && wbp_strobe_i && wbp_sel_i;

    // Read first, so a write returns the byte it replaces
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            wbp_data_o <= mem[ram_addr];
            if (wbp_we_i) begin
                mem[ram_addr] <= wbp_data_i;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wbp_ack_o <= 1'b0;
        end else begin
            wbp_ack_o <= accept;    // One cycle after acceptance
        end
    end

    assign wbp_stall_o = 1'b0;
endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module register_file import common_pkg::*; (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,

    // Wishbone B4 peripheral port
    input  logic [`WB_ADDR_WIDTH-1:0] wbp_addr_i,
    input  logic [`DATA_WIDTH-1:0]    wbp_data_i,
    output logic [`DATA_WIDTH-1:0]    wbp_data_o,
    input  logic                      wbp_we_i,
    input  logic                      wbp_cycle_i,
    input  logic                      wbp_strobe_i,
    input  logic                      wbp_sel_i,      // From the address decoder
    output logic                      wbp_stall_o,
    output logic                      wbp_ack_o,

    // Live status inputs
    input  logic                      video_graphic_i,    // 0 = graphics, 1 = text
    input  logic                      config_crt_i,       // Display type strap
    input  logic                      config_keyboard_i,  // Keyboard layout strap

    // CPU control
    output logic                      cpu_ready_o,
    output logic                      cpu_reset_o,
    output logic                      cpu_nmi_o,

    // Video control
    output logic                      video_col_80_mode_o,
    output logic [1:0]                video_ram_mask_o
);
    // CPU held in reset at power on
    localparam logic [`DATA_WIDTH-1:0] CPU_INIT = `DATA_WIDTH'(1) << `REG_CPU_RESET_BIT;

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] status_next;
    reg_index_t             reg_idx;
    logic                   accept;

    assign reg_idx = reg_index_t'(wbp_addr_i[`REG_ADDR_WIDTH-1:0]);
    assign accept  = wbp_cycle_i && wbp_strobe_i && wbp_sel_i;

    // Status byte, upper bits read as zero
    always_comb begin
        status_next                           = '0;
        status_next[`REG_STATUS_GRAPHICS_BIT] = video_graphic_i;
        status_next[`REG_STATUS_CRT_BIT]      = config_crt_i;
        status_next[`REG_STATUS_KEYBOARD_BIT] = config_keyboard_i;
    end

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            regs[REG_STATUS] <= '0;
            regs[REG_CPU]    <= CPU_INIT;
            regs[REG_VIDEO]  <= '0;     // 40 columns, 1 KB mask
            wbp_ack_o        <= 1'b0;
        end else if (accept) begin
            wbp_ack_o <= 1'b1;
            if (wbp_we_i) begin
                regs[reg_idx] <= wbp_data_i;    // Old value still goes out below
            end
        end else begin
            wbp_ack_o        <= 1'b0;
            regs[REG_STATUS] <= status_next;    // Overwrites any host write to status
        end
    end

    // Registered read of the addressed register, old contents on a write
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            wbp_data_o <= regs[reg_idx];
        end
    end

    assign wbp_stall_o = 1'b0;      // Always single cycle

    assign cpu_ready_o = regs[REG_CPU][`REG_CPU_READY_BIT];
    assign cpu_reset_o = regs[REG_CPU][`REG_CPU_RESET_BIT];
    assign cpu_nmi_o   = regs[REG_CPU][`REG_CPU_NMI_BIT];

    assign video_col_80_mode_o = regs[REG_VIDEO][`REG_VIDEO_COL_80_BIT];
    assign video_ram_mask_o    =
        regs[REG_VIDEO][`REG_VIDEO_RAM_MASK_HI_BIT:`REG_VIDEO_RAM_MASK_LO_BIT];
endmodule

/* hdl/wb_decoder.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module wb_decoder import common_pkg::*; (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,

    // From the bus master
    input  logic                      wbm_cyc_i,
    input  logic                      wbm_stb_i,
    input  logic [`WB_ADDR_WIDTH-1:0] wbm_addr_i,
    output logic [`DATA_WIDTH-1:0]    wbm_data_o,
    output logic                      wbm_ack_o,
    output logic                      wbm_stall_o,

    // Peripheral selects
    output logic                      ram_sel_o,
    output logic                      reg_sel_o,

    // Peripheral replies
    input  logic [`DATA_WIDTH-1:0]    ram_data_i,
    input  logic                      ram_ack_i,
    input  logic                      ram_stall_i,
    input  logic [`DATA_WIDTH-1:0]    reg_data_i,
    input  logic                      reg_ack_i,
    input  logic                      reg_stall_i
);
    localparam logic [`WB_ADDR_WIDTH-1:0] RAM_BASE_ADDR = `RAM_BASE;
    localparam logic [`WB_ADDR_WIDTH-1:0] REG_BASE_ADDR = `REG_BASE;

    periph_sel_t sel;
    logic        unmapped_ack;      // Decoder's own reply for holes in the map

    always_comb begin
        sel = PERIPH_NONE;
        if (wbm_addr_i[`WB_ADDR_WIDTH-1:`RAM_ADDR_WIDTH]
                == RAM_BASE_ADDR[`WB_ADDR_WIDTH-1:`RAM_ADDR_WIDTH]) begin
            sel = PERIPH_RAM;
        end else if (wbm_addr_i[`WB_ADDR_WIDTH-1:`REG_ADDR_WIDTH]
                == REG_BASE_ADDR[`WB_ADDR_WIDTH-1:`REG_ADDR_WIDTH]
                && wbm_addr_i[`REG_ADDR_WIDTH-1:0] < `REG_ADDR_WIDTH'(`REG_COUNT)) begin
            sel = PERIPH_REG;           // Offset 3 stays unmapped
        end
    end

    assign ram_sel_o = (sel == PERIPH_RAM);
    assign reg_sel_o = (sel == PERIPH_REG);

    // Ack unmapped cycles one edge after acceptance, like a real peripheral
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= wbm_cyc_i && wbm_stb_i && (sel == PERIPH_NONE);
        end
    end

    assign wbm_stall_o = (ram_sel_o && ram_stall_i) || (reg_sel_o && reg_stall_i);
    assign wbm_ack_o   = ram_ack_i || reg_ack_i || unmapped_ack;

    // Data follows whichever source acked
    always_comb begin
        if (ram_ack_i) begin
            wbm_data_o = ram_data_i;
        end else if (reg_ack_i) begin
            wbm_data_o = reg_data_i;
        end else begin
            wbm_data_o = `UNMAPPED_DATA;
        end
    end

    assert property (@(posedge wb_clock_i) disable iff (reset_i)
                     $onehot0({ram_ack_i, reg_ack_i, unmapped_ack}))
        else $error("More than one ack source active");
endmodule

/* hdl/wb_host_bridge.sv */
`timescale 1ns/10ps
`include "pet_params.svh"

module wb_host_bridge import common_pkg::*; (
    input  logic                      wb_clock_i,
    input  logic                      reset_i,

    // Host command port
    input  logic                      cmd_valid_i,    // One-cycle pulse
    input  logic                      cmd_we_i,
    input  logic [`WB_ADDR_WIDTH-1:0] cmd_addr_i,
    input  logic [`DATA_WIDTH-1:0]    cmd_data_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic [`DATA_WIDTH-1:0]    rd_data_o,      // Valid with done_o, held after

    // Wishbone B4 pipelined master
    output logic                      wbm_cyc_o,
    output logic                      wbm_stb_o,
    output logic                      wbm_we_o,
    output logic [`WB_ADDR_WIDTH-1:0] wbm_addr_o,
    output logic [`DATA_WIDTH-1:0]    wbm_data_o,
    input  logic [`DATA_WIDTH-1:0]    wbm_data_i,
    input  logic                      wbm_ack_i,
    input  logic                      wbm_stall_i
);
    bridge_state_t state;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            state <= BRIDGE_IDLE;
        end else begin
            case (state)
                BRIDGE_IDLE: begin
                    if (cmd_valid_i) begin
                        state <= BRIDGE_REQUEST;
                    end
                end
                BRIDGE_REQUEST: begin
                    // Strobe is taken on the first edge without stall
                    if (!wbm_stall_i) begin
                        state <= BRIDGE_WAIT_ACK;
                    end
                end
                BRIDGE_WAIT_ACK: begin
                    if (wbm_ack_i) begin
                        state <= BRIDGE_DONE;
                    end
                end
                default: state <= BRIDGE_IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // Command is latched once and held through any stall
    always_ff @(posedge wb_clock_i) begin
        if (state == BRIDGE_IDLE && cmd_valid_i) begin
            wbm_we_o   <= cmd_we_i;
            wbm_addr_o <= cmd_addr_i;
            wbm_data_o <= cmd_data_i;
        end
    end

    // Read data captured on the ack, kept until the next transfer
    always_ff @(posedge wb_clock_i) begin
        if (state == BRIDGE_WAIT_ACK && wbm_ack_i) begin
            rd_data_o <= wbm_data_i;
        end
    end

    assign wbm_stb_o = (state == BRIDGE_REQUEST);
    assign wbm_cyc_o = (state == BRIDGE_REQUEST) || (state == BRIDGE_WAIT_ACK);
    assign busy_o    = (state != BRIDGE_IDLE);
    assign done_o    = (state == BRIDGE_DONE);

    // Host must wait for done before issuing the next command
    assert property (@(posedge wb_clock_i) disable iff (reset_i) cmd_valid_i |-> !busy_o)
        else $error("Host command issued while bridge busy");

    // Peripherals may only ack inside a cycle we opened
    assert property (@(posedge wb_clock_i) disable iff (reset_i) wbm_ack_i |-> wbm_cyc_o)
        else $error("Wishbone ack with cyc low");
endmodule

/* hdl/common_pkg.sv */
`include "pet_params.svh"

package common_pkg;

    // Host bridge FSM
    typedef enum logic [1:0] {
        BRIDGE_IDLE,        // Waiting for a host command
        BRIDGE_REQUEST,     // Strobe out, waiting for stall to clear
        BRIDGE_WAIT_ACK,    // Accepted, waiting for the ack
        BRIDGE_DONE         // One-cycle done pulse
    } bridge_state_t;

    // Register offsets inside the register block
    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        REG_STATUS = 0,     // Live configuration inputs, read only in effect
        REG_CPU    = 1,     // Ready, reset and NMI lines
        REG_VIDEO  = 2      // Column mode and video RAM mask
    } reg_index_t;

    // Target of the current bus cycle
    typedef enum logic [1:0] {
        PERIPH_NONE,        // Unmapped, decoder answers itself
        PERIPH_RAM,
        PERIPH_REG
    } periph_sel_t;

endpackage

/* include/pet_params.svh */
`ifndef PET_PARAMS_SVH
`define PET_PARAMS_SVH

// Bus widths
`define WB_ADDR_WIDTH   12
`define DATA_WIDTH      8

// Register block
`define REG_ADDR_WIDTH  2
`define REG_COUNT       3
`define REG_BASE        12'h800

// Video RAM window, 1 KB
`define RAM_BASE        12'h000
`define RAM_ADDR_WIDTH  10

// Status register bits
`define REG_STATUS_GRAPHICS_BIT  0
`define REG_STATUS_CRT_BIT       1
`define REG_STATUS_KEYBOARD_BIT  2

// CPU register bits
`define REG_CPU_READY_BIT  0
`define REG_CPU_RESET_BIT  1
`define REG_CPU_NMI_BIT    2

// Video register bits
`define REG_VIDEO_COL_80_BIT       0
`define REG_VIDEO_RAM_MASK_LO_BIT  1
`define REG_VIDEO_RAM_MASK_HI_BIT  2

`define UNMAPPED_DATA  8'hff    // Read value for holes in the map

`endif
